/* project.f */
+incdir+source
+incdir+dv
source/rdp_pkg.sv
source/rdp_valid_predict.sv
source/rdp_latency_fifo.sv
source/rdp_read_fifo.sv
source/rdp_afi_return.sv
source/rdp_oct_control.sv
source/rdp_top.sv
dv/rdp_tb.sv

/* Bender.yml */
package:
  name: rdp

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rdp_pkg.sv
      - source/rdp_valid_predict.sv
      - source/rdp_latency_fifo.sv
      - source/rdp_read_fifo.sv
      - source/rdp_afi_return.sv
      - source/rdp_oct_control.sv
      - source/rdp_top.sv
  - target: test
    include_dirs:
      - source
      - dv
    files:
      - dv/rdp_tb.sv

/* dv/rdp_tb_tasks.svh */
/*
 * Testbench helpers for the read datapath
 * Error stop, compare tasks for each DUT result type, the expected
 * time-slot order of a captured word, input drivers and the read return checker
 */

`ifndef RDP_TB_TASKS_SVH
`define RDP_TB_TASKS_SVH

// Prints the reason, then the fail message, and ends the run
task automatic fail_run(input string reason);
	$display("%s", reason);
	$display("** FAIL **");
	$fatal(1, "Stopped at the first error");
endtask

// ************************************************************
// Compare tasks for each kind of DUT result
// ************************************************************
task automatic check_rdata(input rdp_pkg::afi_rdata_t got, input rdp_pkg::afi_rdata_t exp,
	input string what);
	if (got !== exp)
		fail_run($sformatf("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_valid(input rdp_pkg::afi_valid_t got, input rdp_pkg::afi_valid_t exp,
	input string what);
	if (got !== exp)
		fail_run($sformatf("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

task automatic check_dqs_en(input rdp_pkg::dqs_en_t got, input rdp_pkg::dqs_en_t exp,
	input string what);
	if (got !== exp)
		fail_run($sformatf("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

task automatic check_oct(input rdp_pkg::oct_t got, input rdp_pkg::oct_t exp,
	input string what);
	if (got !== exp)
		fail_run($sformatf("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

// Walks the AFI bytes in order and fetches each from its group word
function automatic rdp_pkg::afi_rdata_t slot_order(input rdp_pkg::ddio_word_t word);
	rdp_pkg::afi_rdata_t data;
	rdp_pkg::dq_group_word_t group_word;
	int slot;
	int grp;
	data = '0;
	for (int pos = 0; pos < `RDP_DQS_GROUPS * `RDP_TIME_SLOTS; pos++)
	begin
		// Groups count fastest within each AFI time slot
		slot = pos / `RDP_DQS_GROUPS;
		grp = pos % `RDP_DQS_GROUPS;
		group_word = word[grp*`RDP_GROUP_WORD_WIDTH +: `RDP_GROUP_WORD_WIDTH];
		// Time slot 0 sits in the low byte of a group word
		data[pos*`RDP_DQ_PER_GROUP +: `RDP_DQ_PER_GROUP] =
			group_word[slot*`RDP_DQ_PER_GROUP +: `RDP_DQ_PER_GROUP];
	end
	return data;
endfunction

// ************************************************************
// Input drivers that act on the rising edge
// ************************************************************
task automatic idle_cycles(input int n);
	repeat (n) @(posedge pll_afi_clk);
endtask

// Captures one random word per cycle and records each on the scoreboard
task automatic capture_words(input int n);
	rdp_pkg::ddio_word_t word;
	for (int i = 0; i < n; i++)
	begin
		@(posedge pll_afi_clk);
		word = {$urandom, $urandom};
		capture_strobe_i <= 1'b1;
		ddio_dq_i <= word;
		capture_q.push_back(word);
	end
	@(posedge pll_afi_clk);
	capture_strobe_i <= 1'b0;
endtask

// Issues back-to-back requests and returns in cycle T+n of the first one
task automatic issue_reads(input int n);
	for (int i = 0; i < n; i++)
	begin
		@(posedge pll_afi_clk);
		afi_rdata_en_full_i <= '1;
	end
	@(posedge pll_afi_clk);
	afi_rdata_en_full_i <= '0;
endtask

// Drives a single-cycle sequencer op and then returns to idle
task automatic seq_command(input rdp_pkg::seq_op_e op, input rdp_pkg::group_sel_t group);
	@(posedge pll_afi_clk);
	seq_op_i <= op;
	seq_group_i <= group;
	@(posedge pll_afi_clk);
	seq_op_i <= rdp_pkg::SEQ_OP_NONE;
endtask

// Latency only changes once the latency shift register has drained
task automatic set_latency(input int lat);
	idle_cycles(`RDP_MAX_READ_LATENCY + 2);
	@(posedge pll_afi_clk);
	seq_read_latency_i <= rdp_pkg::latency_t'(lat);
	read_latency = lat;
endtask

// Waits for read valid from cycle T+start_cycle, checks its cycle, then
// checks n_reads beats in a row against the scoreboard and the idle beat after
task automatic return_reads(input int n_reads, input int start_cycle);
	int cycle;
	rdp_pkg::afi_rdata_t exp_data;
	cycle = start_cycle;
	@(negedge pll_afi_clk);
	while (afi_rdata_valid_o == '0)
	begin
		if (cycle > `RDP_MAX_READ_LATENCY + 4)
		begin
			fail_run("Timed out waiting for AFI read valid of a read request");
		end
		else
		begin
			@(negedge pll_afi_clk);
			cycle++;
		end
	end
	if (cycle != read_latency + 1)
		fail_run($sformatf("FAILED at time %0t: read valid in cycle T+%0d, expected T+%0d",
			$time, cycle, read_latency + 1));
	for (int beat = 0; beat < n_reads; beat++)
	begin
		if (beat > 0)
			@(negedge pll_afi_clk);
		check_valid(afi_rdata_valid_o, '1, "read valid during a return beat");
		if (capture_q.size() == 0)
			fail_run("A read returned with no captured word left to compare against");
		exp_data = slot_order(capture_q.pop_front());
		check_rdata(afi_rdata_o, exp_data, "returned read data");
	end
	@(negedge pll_afi_clk);
	check_valid(afi_rdata_valid_o, '0, "read valid after the last beat");
endtask

`endif

/* dv/rdp_tb.sv */
/*
 * Testbench top of the read datapath
 * Clock and reset, DUT instance, the directed tests and the run report
 */

`default_nettype none

`include "rdp_params.svh"

module rdp_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// Termination stays on from the request through five more cycles
	localparam int OCT_LOW_CYCLES = 6;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	rdp_pkg::afi_valid_t afi_rdata_en_full_i;
	logic capture_strobe_i;
	rdp_pkg::ddio_word_t ddio_dq_i;
	rdp_pkg::seq_op_e seq_op_i;
	rdp_pkg::group_sel_t seq_group_i;
	rdp_pkg::latency_t seq_read_latency_i;
	rdp_pkg::afi_rdata_t afi_rdata_o;
	rdp_pkg::afi_valid_t afi_rdata_valid_o;
	rdp_pkg::dqs_en_t dqs_enable_ctrl_o;
	rdp_pkg::oct_t force_oct_off_o;

	// Captured words in write order, which is also the read order
	rdp_pkg::ddio_word_t capture_q[$];
	int read_latency;

	`include "rdp_tb_tasks.svh"

	always #50 pll_afi_clk = ~pll_afi_clk;

	rdp_top rdp_top_inst
	(
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.capture_strobe_i    (capture_strobe_i),
		.ddio_dq_i           (ddio_dq_i),
		.seq_op_i            (seq_op_i),
		.seq_group_i         (seq_group_i),
		.seq_read_latency_i  (seq_read_latency_i),
		.afi_rdata_o         (afi_rdata_o),
		.afi_rdata_valid_o   (afi_rdata_valid_o),
		.dqs_enable_ctrl_o   (dqs_enable_ctrl_o),
		.force_oct_off_o     (force_oct_off_o)
	);

	// ************************************************************
	// Directed tests
	// ************************************************************
	task automatic test_reset();
		check_valid(afi_rdata_valid_o, '0, "read valid after reset");
		check_dqs_en(dqs_enable_ctrl_o, '0, "DQS enable after reset");
		check_oct(force_oct_off_o, '0, "OCT force off after reset");
	endtask

	// Separate reads come back in capture order, L+1 cycles after the request
	task automatic test_latency_order();
		set_latency(6);
		capture_words(4);
		repeat (4)
		begin
			issue_reads(1);
			return_reads(1, 1);
			idle_cycles(3);
		end
	endtask

	task automatic test_reads_in_flight();
		set_latency(9);
		capture_words(4);
		issue_reads(4);
		return_reads(4, 4);
	endtask

	// Group 1 moves its write position by two, group 0 takes the full-rate shift
	task automatic test_valid_predict();
		int wr_pos [`RDP_DQS_GROUPS];
		int fr_one [`RDP_DQS_GROUPS];
		rdp_pkg::dqs_en_t exp_en;
		capture_words(1);
		seq_command(rdp_pkg::SEQ_OP_INC_HR, 1'b1);
		seq_command(rdp_pkg::SEQ_OP_INC_HR, 1'b1);
		seq_command(rdp_pkg::SEQ_OP_INC_FR, 1'b0);
		wr_pos[0] = 0;
		fr_one[0] = 1;
		wr_pos[1] = 2;
		fr_one[1] = 0;
		idle_cycles(2);
		@(posedge pll_afi_clk);
		afi_rdata_en_full_i <= '1;
		for (int k = 0; k <= read_latency; k++)
		begin
			exp_en = '0;
			for (int g = 0; g < `RDP_DQS_GROUPS; g++)
			begin
				// Phase 1 lands at T+2+a; phase 0 is one cycle later when shifted
				if (k == 2 + wr_pos[g] + fr_one[g])
					exp_en[g] = 1'b1;
				if (k == 2 + wr_pos[g])
					exp_en[g + `RDP_DQS_GROUPS] = 1'b1;
			end
			@(negedge pll_afi_clk);
			check_dqs_en(dqs_enable_ctrl_o, exp_en, $sformatf("DQS enable in cycle T+%0d", k));
			@(posedge pll_afi_clk);
			afi_rdata_en_full_i <= '0;
		end
		return_reads(1, read_latency + 1);
	endtask

	// Words captured before the FIFO reset are lost
	task automatic test_fifo_reset();
		capture_words(2);
		seq_command(rdp_pkg::SEQ_OP_FIFO_RESET, 1'b0);
		capture_q.delete();
		capture_words(1);
		issue_reads(1);
		return_reads(1, 1);
	endtask

	task automatic test_oct_window();
		rdp_pkg::oct_t exp_oct;
		capture_words(1);
		idle_cycles(`RDP_OCT_OFF_DELAY + 4);
		@(posedge pll_afi_clk);
		afi_rdata_en_full_i <= '1;
		for (int k = 0; k <= read_latency; k++)
		begin
			exp_oct = (k >= 1 && k <= OCT_LOW_CYCLES) ? '0 : '1;
			@(negedge pll_afi_clk);
			check_oct(force_oct_off_o, exp_oct, $sformatf("OCT force off in cycle T+%0d", k));
			@(posedge pll_afi_clk);
			afi_rdata_en_full_i <= '0;
		end
		return_reads(1, read_latency + 1);
	endtask

	initial
	begin
		void'($urandom(77319));
		pll_afi_clk = 1'b0;
		reset_n_afi_clk = 1'b0;
		afi_rdata_en_full_i = '0;
		capture_strobe_i = 1'b0;
		ddio_dq_i = '0;
		seq_op_i = rdp_pkg::SEQ_OP_NONE;
		seq_group_i = '0;
		seq_read_latency_i = rdp_pkg::latency_t'(6);
		read_latency = 6;
		repeat (10) @(posedge pll_afi_clk);
		reset_n_afi_clk <= 1'b1;
		// Registered outputs have not been clocked out of reset yet
		@(negedge pll_afi_clk);
		test_reset();
		test_latency_order();
		test_reads_in_flight();
		test_valid_predict();
		test_fifo_reset();
		test_oct_window();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* source/rdp_top.sv */
/*
 * Top level of the read datapath
 * Latency FIFO makes the read strobe, the read data FIFOs buffer captured
 * words, the return stage hands them to the AFI; valid prediction and
 * termination control run beside them off the same read enable
 */

`default_nettype none

module rdp_top
(
	input  wire                      pll_afi_clk,
	input  wire                      reset_n_afi_clk,
	input  wire rdp_pkg::afi_valid_t afi_rdata_en_full_i,
	input  wire                      capture_strobe_i,
	input  wire rdp_pkg::ddio_word_t ddio_dq_i,
	input  wire rdp_pkg::seq_op_e    seq_op_i,
	input  wire rdp_pkg::group_sel_t seq_group_i,
	input  wire rdp_pkg::latency_t   seq_read_latency_i,
	output rdp_pkg::afi_rdata_t      afi_rdata_o,
	output rdp_pkg::afi_valid_t      afi_rdata_valid_o,
	output rdp_pkg::dqs_en_t         dqs_enable_ctrl_o,
	output rdp_pkg::oct_t            force_oct_off_o
);

	// Read strobe from the latency FIFO, one pulse per read request
	logic read_strobe;

	// Oldest word of every group FIFO, still in group order
	rdp_pkg::ddio_word_t fifo_rdata;

	// DQS enable tokens, one shifter pair per group
	rdp_valid_predict rdp_valid_predict_inst
	(
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.seq_op_i            (seq_op_i),
		.seq_group_i         (seq_group_i),
		.dqs_enable_ctrl_o   (dqs_enable_ctrl_o)
	);

	rdp_latency_fifo rdp_latency_fifo_inst
	(
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.seq_read_latency_i  (seq_read_latency_i),
		.read_strobe_o       (read_strobe)
	);

	rdp_read_fifo rdp_read_fifo_inst
	(
		.pll_afi_clk      (pll_afi_clk),
		.reset_n_afi_clk  (reset_n_afi_clk),
		.capture_strobe_i (capture_strobe_i),
		.ddio_dq_i        (ddio_dq_i),
		.read_strobe_i    (read_strobe),
		.seq_op_i         (seq_op_i),
		.fifo_rdata_o     (fifo_rdata)
	);

	// Reorders to time-slot order and registers data and valid
	rdp_afi_return rdp_afi_return_inst
	(
		.pll_afi_clk       (pll_afi_clk),
		.reset_n_afi_clk   (reset_n_afi_clk),
		.read_strobe_i     (read_strobe),
		.fifo_rdata_i      (fifo_rdata),
		.afi_rdata_o       (afi_rdata_o),
		.afi_rdata_valid_o (afi_rdata_valid_o)
	);

	rdp_oct_control rdp_oct_control_inst
	(
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_o     (force_oct_off_o)
	);

endmodule

`default_nettype wire

/* source/rdp_oct_control.sv */
/*
 * On-die termination control
 * Forces termination off once no read enable falls in the recent window
 */

`default_nettype none

`include "rdp_params.svh"

module rdp_oct_control
(
	input  wire                      pll_afi_clk,
	input  wire                      reset_n_afi_clk,
	input  wire rdp_pkg::afi_valid_t afi_rdata_en_full_i,
	output rdp_pkg::oct_t            force_oct_off_o
);

	// Last RDP_OCT_OFF_DELAY enables, newest in bit 0
	logic [`RDP_OCT_OFF_DELAY-1:0] rdata_en_r;
	logic [`RDP_OCT_OFF_DELAY:0] rdata_en_window;

	assign rdata_en_window = {rdata_en_r, afi_rdata_en_full_i[0]};

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_r <= '0;
			force_oct_off_o <= '0;
		end
		else
		begin
			rdata_en_r <= rdata_en_window[`RDP_OCT_OFF_DELAY-1:0];
			// Termination stays on while any enable is inside the window
			force_oct_off_o <= {`RDP_DQS_GROUPS{
				~(|rdata_en_window[`RDP_OCT_OFF_DELAY:`RDP_OCT_ON_DELAY])}};
		end
	end

endmodule

`default_nettype wire

/* source/rdp_afi_return.sv */
/*
 * AFI return stage
 * Registers the FIFO word in time-slot order and drives AFI read valid
 */

`default_nettype none

`include "rdp_params.svh"

module rdp_afi_return
(
	input  wire                      pll_afi_clk,
	input  wire                      reset_n_afi_clk,
	input  wire                      read_strobe_i,
	input  wire rdp_pkg::ddio_word_t fifo_rdata_i,
	output rdp_pkg::afi_rdata_t      afi_rdata_o,
	output rdp_pkg::afi_valid_t      afi_rdata_valid_o
);

	localparam int DQ_W = `RDP_DQ_PER_GROUP;

	rdp_pkg::afi_rdata_t rdata_remap;

	// FIFO side is group then slot; AFI side is slot then group
	always_comb
	begin
		for (int t = 0; t < `RDP_TIME_SLOTS; t++)
		begin
			for (int g = 0; g < `RDP_DQS_GROUPS; g++)
			begin
				rdata_remap[(t*`RDP_DQS_GROUPS + g)*DQ_W +: DQ_W] =
					fifo_rdata_i[(g*`RDP_TIME_SLOTS + t)*DQ_W +: DQ_W];
			end
		end
	end

	// Data holds its last value between reads
	always_ff @(posedge pll_afi_clk)
	begin
		if (read_strobe_i)
			afi_rdata_o <= rdata_remap;
	end

	// Both phases carry data for every read
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			afi_rdata_valid_o <= '0;
		else
			afi_rdata_valid_o <= {`RDP_AFI_RATE{read_strobe_i}};
	end

endmodule

`default_nettype wire

/* source/rdp_read_fifo.sv */
/*
 * Read data FIFOs
 * One flop-based FIFO per DQS group, written on the capture strobe, read
 * on the read strobe, pointers cleared by the sequencer FIFO reset
 */

`default_nettype none

`include "rdp_params.svh"

module rdp_read_fifo
(
	input  wire                      pll_afi_clk,
	input  wire                      reset_n_afi_clk,
	input  wire                      capture_strobe_i,
	input  wire rdp_pkg::ddio_word_t ddio_dq_i,
	input  wire                      read_strobe_i,
	input  wire rdp_pkg::seq_op_e    seq_op_i,
	output rdp_pkg::ddio_word_t      fifo_rdata_o
);

	localparam int ADDR_W = $clog2(`RDP_READ_FIFO_DEPTH);
	localparam int WORD_W = `RDP_GROUP_WORD_WIDTH;

	logic fifo_reset;

	// The sequencer resets every group at once
	assign fifo_reset = (seq_op_i == rdp_pkg::SEQ_OP_FIFO_RESET);

	for (genvar g = 0; g < `RDP_DQS_GROUPS; g++)
	begin : group_gen
		rdp_pkg::dq_group_word_t fifo_mem [`RDP_READ_FIFO_DEPTH];
		rdp_pkg::rfifo_ptr_t wr_ptr;
		rdp_pkg::rfifo_ptr_t rd_ptr;
		logic fifo_full;
		logic fifo_empty;

		// Pointers match when empty and differ only in the wrap bit when full
		assign fifo_empty = (wr_ptr == rd_ptr);
		assign fifo_full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
			(wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

		// ************************************************************
		// Storage and pointers
		// ************************************************************
		always_ff @(posedge pll_afi_clk)
		begin
			if (capture_strobe_i)
				fifo_mem[wr_ptr[ADDR_W-1:0]] <= ddio_dq_i[g*WORD_W +: WORD_W];
		end

		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
		begin
			if (!reset_n_afi_clk)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
			end
			else if (fifo_reset)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
			end
			else
			begin
				if (capture_strobe_i)
					wr_ptr <= wr_ptr + 1'b1;
				if (read_strobe_i)
					rd_ptr <= rd_ptr + 1'b1;
			end
		end

		// Oldest entry is visible while the read strobe is high
		assign fifo_rdata_o[g*WORD_W +: WORD_W] = fifo_mem[rd_ptr[ADDR_W-1:0]];

		// Capture must never outrun the reads issued through the latency FIFO
		assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			capture_strobe_i && !fifo_reset |-> !fifo_full)
		else $error("write to full read FIFO of group %0d", g);

		// A read strobe with no captured word means the latency is too short
		assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			read_strobe_i && !fifo_reset |-> !fifo_empty)
		else $error("read from empty read FIFO of group %0d", g);
	end

endmodule

`default_nettype wire

/* source/rdp_latency_fifo.sv */
/*
 * Read latency FIFO
 * Delays the read enable through a shift register and taps it at the
 * latency set by the sequencer, giving the registered read strobe
 */

`default_nettype none

`include "rdp_params.svh"

module rdp_latency_fifo
(
	input  wire                      pll_afi_clk,
	input  wire                      reset_n_afi_clk,
	input  wire rdp_pkg::afi_valid_t afi_rdata_en_full_i,
	input  wire rdp_pkg::latency_t   seq_read_latency_i,
	output logic                     read_strobe_o
);

	logic [`RDP_MAX_READ_LATENCY-1:0] latency_shifter;
	rdp_pkg::latency_t tap_sel;

	// Bit k holds a request made k+1 cycles ago
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			latency_shifter <= '0;
		else
			latency_shifter <= {latency_shifter[`RDP_MAX_READ_LATENCY-2:0],
				afi_rdata_en_full_i[0]};
	end

	// The shifter and the output register together take two cycles
	assign tap_sel = seq_read_latency_i - rdp_pkg::latency_t'(`RDP_MIN_READ_LATENCY);

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			read_strobe_o <= 1'b0;
		else
			read_strobe_o <= latency_shifter[tap_sel];
	end

	// Changing the latency below the minimum with reads in flight would
	// wrap the tap and lose or duplicate strobes
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(|latency_shifter) |->
		seq_read_latency_i inside {[`RDP_MIN_READ_LATENCY:`RDP_MAX_READ_LATENCY-1]})
	else $error("read latency out of range with reads in flight");

endmodule

`default_nettype wire

/* source/rdp_valid_predict.sv */
/*
 * Read valid prediction
 * Per DQS group: write position, full-rate shift state, a registered
 * full-rate cycle shifter and one token shift register per AFI phase
 */

`default_nettype none

`include "rdp_params.svh"

module rdp_valid_predict
(
	input  wire                      pll_afi_clk,
	input  wire                      reset_n_afi_clk,
	input  wire rdp_pkg::afi_valid_t afi_rdata_en_full_i,
	input  wire rdp_pkg::seq_op_e    seq_op_i,
	input  wire rdp_pkg::group_sel_t seq_group_i,
	output rdp_pkg::dqs_en_t         dqs_enable_ctrl_o
);

	// A read request in half rate writes one token per phase. The token
	// shifters drain toward bit 0 once per AFI cycle, so the write position
	// sets the delay in whole AFI cycles and the full-rate shift adds half
	// of one by sliding the tokens by a single phase

	for (genvar g = 0; g < `RDP_DQS_GROUPS; g++)
	begin : group_gen
		rdp_pkg::vfifo_addr_t wr_addr;
		rdp_pkg::fr_shift_e fr_shift;
		rdp_pkg::afi_valid_t rdata_en_r;
		logic rdata_en_hi_rr;
		rdp_pkg::afi_valid_t qvld_in;
		logic group_hit;

		assign group_hit = (seq_group_i == rdp_pkg::group_sel_t'(g));

		// ************************************************************
		// Sequencer control of write position and shift state
		// ************************************************************
		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
		begin
			if (!reset_n_afi_clk)
			begin
				wr_addr <= '0;
				fr_shift <= rdp_pkg::FR_SHIFT_NONE;
			end
			else if (group_hit)
			begin
				// A half-rate step moves the write position and undoes any
				// full-rate shift, so the two together cover every phase
				if (seq_op_i == rdp_pkg::SEQ_OP_INC_HR)
				begin
					wr_addr <= wr_addr + 1'b1;
					fr_shift <= rdp_pkg::FR_SHIFT_NONE;
				end
				else if (seq_op_i == rdp_pkg::SEQ_OP_INC_FR)
				begin
					fr_shift <= rdp_pkg::FR_SHIFT_ONE;
				end
			end
		end

		// Full-rate cycle shifter, the high phase gets a second stage
		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
		begin
			if (!reset_n_afi_clk)
			begin
				rdata_en_r <= '0;
				rdata_en_hi_rr <= 1'b0;
			end
			else
			begin
				rdata_en_r <= afi_rdata_en_full_i;
				rdata_en_hi_rr <= rdata_en_r[`RDP_AFI_RATE-1];
			end
		end

		// With a shift, phase 0 moves up to phase 1 and phase 1 wraps into
		// phase 0 of the next AFI cycle
		always_comb
		begin
			if (fr_shift == rdp_pkg::FR_SHIFT_ONE)
				qvld_in = {rdata_en_r[0], rdata_en_hi_rr};
			else
				qvld_in = rdata_en_r;
		end

		for (genvar ph = 0; ph < `RDP_AFI_RATE; ph++)
		begin : phase_gen
			logic [`RDP_VFIFO_DEPTH-1:0] qvld_shifter;

			// Shift down and drop the new token at the write position
			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
			begin
				if (!reset_n_afi_clk)
				begin
					qvld_shifter <= '0;
				end
				else
				begin
					qvld_shifter <= {1'b0, qvld_shifter[`RDP_VFIFO_DEPTH-1:1]};
					qvld_shifter[wr_addr] <= qvld_in[ph];
				end
			end

			assign dqs_enable_ctrl_o[g + `RDP_DQS_GROUPS*ph] = qvld_shifter[0];
		end
	end

	// An unknown opcode would leave the write positions of all groups unknown
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		!$isunknown(seq_op_i))
	else $error("seq_op_i is unknown");

endmodule

`default_nettype wire

/* source/rdp_pkg.sv */
/*
 * Shared types of the read datapath
 * Data words in both orderings, valid and enable vectors, pointer and
 * latency types, the sequencer opcode and the full-rate shift state
 */

`default_nettype none

`include "rdp_params.svh"

package rdp_pkg;

	// One group's four time slots, time slot 0 in the low byte
	typedef logic [`RDP_GROUP_WORD_WIDTH-1:0] dq_group_word_t;

	// Captured word, ordered by group and then by time slot
	typedef logic [`RDP_DATA_WIDTH-1:0] ddio_word_t;

	// AFI read data, ordered by time slot and then by group
	typedef logic [`RDP_DATA_WIDTH-1:0] afi_rdata_t;

	// One bit per AFI phase
	typedef logic [`RDP_AFI_RATE-1:0] afi_valid_t;

	// DQS enable bits, indexed as group + groups * phase
	typedef logic [`RDP_DQS_GROUPS*`RDP_AFI_RATE-1:0] dqs_en_t;

	typedef logic [$clog2(`RDP_DQS_GROUPS)-1:0] group_sel_t;
	typedef logic [$clog2(`RDP_VFIFO_DEPTH)-1:0] vfifo_addr_t;

	// Extra top bit tells a full FIFO from an empty one
	typedef logic [$clog2(`RDP_READ_FIFO_DEPTH):0] rfifo_ptr_t;

	typedef logic [$clog2(`RDP_MAX_READ_LATENCY)-1:0] latency_t;
	typedef logic [`RDP_DQS_GROUPS-1:0] oct_t;

	// Sequencer command, idles at SEQ_OP_NONE between single-cycle ops
	typedef enum logic [1:0]
	{
		SEQ_OP_NONE       = 2'd0,
		SEQ_OP_INC_FR     = 2'd1,
		SEQ_OP_INC_HR     = 2'd2,
		SEQ_OP_FIFO_RESET = 2'd3
	} seq_op_e;

	// Full-rate cycle shift applied to the valid-prediction tokens
	typedef enum logic
	{
		FR_SHIFT_NONE = 1'b0,
		FR_SHIFT_ONE  = 1'b1
	} fr_shift_e;

endpackage

`default_nettype wire

/* source/rdp_params.svh */
/*
 * Build parameters of the DDR2 PHY read datapath
 * Group count, data widths, FIFO and shifter depths, read latency limits
 * and the on-die termination window derived from the memory read latency
 */

`ifndef RDP_PARAMS_SVH
`define RDP_PARAMS_SVH

// Interface shape, half rate with two DQS groups
`define RDP_DQS_GROUPS        2
`define RDP_DQ_PER_GROUP      8
`define RDP_AFI_RATE          2

// One AFI cycle carries two time slots per AFI phase
`define RDP_TIME_SLOTS        (2 * `RDP_AFI_RATE)
`define RDP_GROUP_WORD_WIDTH  (`RDP_TIME_SLOTS * `RDP_DQ_PER_GROUP)
`define RDP_DATA_WIDTH        (`RDP_DQS_GROUPS * `RDP_GROUP_WORD_WIDTH)

// Storage depths
`define RDP_VFIFO_DEPTH       8
`define RDP_READ_FIFO_DEPTH   8
`define RDP_MAX_READ_LATENCY  16
`define RDP_MIN_READ_LATENCY  2

// Memory read latency and the termination window it implies
`define RDP_MEM_T_RL          5
`define RDP_OCT_ON_DELAY      ((`RDP_MEM_T_RL > 4) ? ((`RDP_MEM_T_RL - 4) / 2) : 0)
`define RDP_OCT_OFF_DELAY     ((`RDP_MEM_T_RL + 6) / 2)

`endif
